/* source/packetizer_pkg.sv */
package packetizer_pkg;

    localparam int word_width = 8;

    localparam int act_addr_width = 11;
    localparam int act_data_width = 8;
    localparam int param_addr_width = 13;
    localparam int param_data_width = 128;
    localparam int inst_addr_width = 6;
    localparam int inst_data_width = 80;

    // Builder registers are sized for the widest memory
    localparam int max_addr_width = 13;
    localparam int max_data_width = 128;

    typedef enum logic [1:0] {target_reg, target_param, target_act, target_inst} target_e;

    typedef enum logic {op_mem_write, op_read_back} op_e;

    typedef enum logic [2:0] {
        st_header, st_reg, st_burst_len, st_addr, st_data, st_commit, st_next, st_done
    } seq_state_e;

    // Address field length in bytes
    function automatic int addr_bytes(target_e target);
        case (target)
            target_act:   return 2;
            target_param: return 2;
            target_inst:  return 1;
            default:      return 0;
        endcase
    endfunction

    // Data field length in bytes
    function automatic int data_bytes(target_e target);
        case (target)
            target_act:   return 1;
            target_param: return 16;
            target_inst:  return 10;
            default:      return 0;
        endcase
    endfunction

endpackage

/* source/field_bus_if.sv */
`timescale 1ns/10ps

interface field_bus_if;

    logic [packetizer_pkg::word_width-1:0] word;
    packetizer_pkg::target_e               target;
    logic                                  load_addr;
    logic                                  load_data;
    logic                                  start;
    logic                                  next_word;
    logic                                  addr_full;
    logic                                  data_full;

    modport sequencer (
        output word, target, load_addr, load_data, start, next_word,
        input  addr_full, data_full
    );

    modport addr_side (
        input  word, target, load_addr, start, next_word,
        output addr_full
    );

    modport data_side (
        input  word, target, load_data, start, next_word,
        output data_full
    );

    modport router (
        input  target
    );

endinterface

/* source/packet_sequencer.sv */
`timescale 1ns/10ps

module packet_sequencer #(
    parameter int burst_count_width = 12,
    parameter int sync_stages = 2
) (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  chip_select_n,
    input  logic [packetizer_pkg::word_width-1:0] spi_word,
    input  logic                                  read_fifo_empty,
    output logic                                  rd_req,
    field_bus_if.sequencer                        bus,
    output logic                                  commit,
    output logic                                  proc_enable,
    output logic                                  proc_reset
);

    logic [sync_stages-1:0]                cs_sync_q;
    logic                                  cs_high;
    packetizer_pkg::seq_state_e            state;
    logic [packetizer_pkg::word_width-1:0] header;
    logic [1:0]                            len_count;
    logic [burst_count_width-1:0]          burst_limit;
    logic [burst_count_width-1:0]          word_count;
    logic                                  want_byte;
    logic                                  header_valid;
    packetizer_pkg::op_e                   header_op;
    packetizer_pkg::target_e               header_target;

    // Chip select crosses from the SPI side
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cs_sync_q <= '1;
        end else begin
            cs_sync_q <= {cs_sync_q[sync_stages-2:0], chip_select_n};
        end
    end

    assign cs_high = cs_sync_q[sync_stages-1];

    // Decode of the head byte while it is being popped
    assign header_valid = (spi_word[3:2] == 2'b11);
    assign header_op = packetizer_pkg::op_e'(spi_word[5]);
    assign header_target = packetizer_pkg::target_e'(spi_word[7:6]);

    assign bus.word = spi_word;
    assign bus.target = packetizer_pkg::target_e'(header[7:6]);
    assign bus.start = rd_req && (state == packetizer_pkg::st_header);
    assign bus.load_addr = rd_req && (state == packetizer_pkg::st_addr);
    assign bus.load_data = rd_req && (state == packetizer_pkg::st_data);
    assign bus.next_word = (state == packetizer_pkg::st_next);

    assign commit = (state == packetizer_pkg::st_commit) && !cs_high;

    always_comb begin
        case (state)
            packetizer_pkg::st_header:    want_byte = 1'b1;
            packetizer_pkg::st_burst_len: want_byte = 1'b1;
            packetizer_pkg::st_addr:      want_byte = !bus.addr_full;
            packetizer_pkg::st_data:      want_byte = !bus.data_full;
            default:                      want_byte = 1'b0;
        endcase
    end

    // One pop, then at least one idle cycle for the FIFO head to settle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_req <= 1'b0;
        end else begin
            rd_req <= !cs_high && !rd_req && want_byte && !read_fifo_empty;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= packetizer_pkg::st_header;
            header <= '0;
            len_count <= '0;
            burst_limit <= '0;
            word_count <= '0;
            proc_enable <= 1'b0;
            proc_reset <= 1'b0;
        end else if (cs_high) begin
            // Deselect abandons whatever packet is in flight
            state <= packetizer_pkg::st_header;
        end else begin
            case (state)
                packetizer_pkg::st_header: begin
                    if (rd_req) begin
                        header <= spi_word;
                        len_count <= '0;
                        burst_limit <= '0;
                        word_count <= '0;
                        if (!header_valid || header_op == packetizer_pkg::op_read_back) begin
                            state <= packetizer_pkg::st_header;
                        end else if (header_target == packetizer_pkg::target_reg) begin
                            state <= packetizer_pkg::st_reg;
                        end else if (spi_word[4] && spi_word[1:0] != 2'b00) begin
                            state <= packetizer_pkg::st_burst_len;
                        end else begin
                            state <= packetizer_pkg::st_addr;
                        end
                    end
                end
                packetizer_pkg::st_reg: begin
                    proc_enable <= header[1];
                    proc_reset <= header[0];
                    state <= packetizer_pkg::st_done;
                end
                packetizer_pkg::st_burst_len: begin
                    if (rd_req) begin
                        burst_limit <= {burst_limit[burst_count_width-packetizer_pkg::word_width-1:0],
                                        spi_word};
                        len_count <= len_count + 2'd1;
                        if (len_count + 2'd1 == header[1:0]) begin
                            state <= packetizer_pkg::st_addr;
                        end
                    end
                end
                packetizer_pkg::st_addr: begin
                    if (bus.addr_full) begin
                        state <= packetizer_pkg::st_data;
                    end
                end
                packetizer_pkg::st_data: begin
                    if (bus.data_full) begin
                        state <= packetizer_pkg::st_commit;
                    end
                end
                packetizer_pkg::st_commit: begin
                    // Burst of length n writes n+1 words
                    if (header[4] && word_count != burst_limit) begin
                        word_count <= word_count + 1'b1;
                        state <= packetizer_pkg::st_next;
                    end else begin
                        state <= packetizer_pkg::st_done;
                    end
                end
                packetizer_pkg::st_next: begin
                    state <= packetizer_pkg::st_data;
                end
                packetizer_pkg::st_done: begin
                    // Held until chip select rises
                    state <= packetizer_pkg::st_done;
                end
                default: begin
                    state <= packetizer_pkg::st_header;
                end
            endcase
        end
    end

endmodule

/* source/address_builder.sv */
`timescale 1ns/10ps

module address_builder (
    input  logic                                      clk,
    input  logic                                      reset_n,
    field_bus_if.addr_side                            bus,
    output logic [packetizer_pkg::max_addr_width-1:0] addr_value
);

    logic [1:0] byte_count;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_count <= '0;
            bus.addr_full <= 1'b0;
        end else if (bus.start) begin
            byte_count <= '0;
            bus.addr_full <= 1'b0;
        end else if (bus.load_addr) begin
            byte_count <= byte_count + 2'd1;
            if (int'(byte_count) + 1 == packetizer_pkg::addr_bytes(bus.target)) begin
                bus.addr_full <= 1'b1;
            end
        end
    end

    // Bytes enter at the low end, so the last byte is least significant
    always_ff @(posedge clk) begin
        if (bus.start) begin
            addr_value <= '0;
        end else if (bus.load_addr) begin
            addr_value <= {addr_value[packetizer_pkg::max_addr_width-packetizer_pkg::word_width-1:0],
                           bus.word};
        end else if (bus.next_word) begin
            addr_value <= addr_value + 1'b1;
        end
    end

endmodule

/* source/data_builder.sv */
`timescale 1ns/10ps

module data_builder (
    input  logic                                      clk,
    input  logic                                      reset_n,
    field_bus_if.data_side                            bus,
    output logic [packetizer_pkg::max_data_width-1:0] data_value
);

    logic [4:0] byte_count;
    logic       clear;

    // Each burst word starts from an empty register
    assign clear = bus.start || bus.next_word;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_count <= '0;
            bus.data_full <= 1'b0;
        end else if (clear) begin
            byte_count <= '0;
            bus.data_full <= 1'b0;
        end else if (bus.load_data) begin
            byte_count <= byte_count + 5'd1;
            if (int'(byte_count) + 1 == packetizer_pkg::data_bytes(bus.target)) begin
                bus.data_full <= 1'b1;
            end
        end
    end

    // First byte ends up at the top of the target-width slice
    always_ff @(posedge clk) begin
        if (clear) begin
            data_value <= '0;
        end else if (bus.load_data) begin
            data_value <= {data_value[packetizer_pkg::max_data_width-packetizer_pkg::word_width-1:0],
                           bus.word};
        end
    end

endmodule

/* source/memory_router.sv */
`timescale 1ns/10ps

module memory_router (
    input  logic                                        clk,
    input  logic                                        reset_n,
    field_bus_if.router                                 bus,
    input  logic [packetizer_pkg::max_addr_width-1:0]   addr_value,
    input  logic [packetizer_pkg::max_data_width-1:0]   data_value,
    input  logic                                        commit,
    output logic [packetizer_pkg::act_addr_width-1:0]   act_mem_addr,
    output logic [packetizer_pkg::act_data_width-1:0]   act_mem_data,
    output logic                                        act_mem_wren,
    output logic [packetizer_pkg::param_addr_width-1:0] param_mem_addr,
    output logic [packetizer_pkg::param_data_width-1:0] param_mem_data,
    output logic                                        param_mem_wren,
    output logic [packetizer_pkg::inst_addr_width-1:0]  inst_mem_addr,
    output logic [packetizer_pkg::inst_data_width-1:0]  inst_mem_data,
    output logic                                        inst_mem_wren
);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            act_mem_wren <= 1'b0;
            param_mem_wren <= 1'b0;
            inst_mem_wren <= 1'b0;
        end else begin
            act_mem_wren <= commit && (bus.target == packetizer_pkg::target_act);
            param_mem_wren <= commit && (bus.target == packetizer_pkg::target_param);
            inst_mem_wren <= commit && (bus.target == packetizer_pkg::target_inst);
        end
    end

    // Only the addressed memory's outputs change, the rest hold
    always_ff @(posedge clk) begin
        if (commit) begin
            case (bus.target)
                packetizer_pkg::target_act: begin
                    act_mem_addr <= addr_value[packetizer_pkg::act_addr_width-1:0];
                    act_mem_data <= data_value[packetizer_pkg::act_data_width-1:0];
                end
                packetizer_pkg::target_param: begin
                    param_mem_addr <= addr_value[packetizer_pkg::param_addr_width-1:0];
                    param_mem_data <= data_value[packetizer_pkg::param_data_width-1:0];
                end
                packetizer_pkg::target_inst: begin
                    inst_mem_addr <= addr_value[packetizer_pkg::inst_addr_width-1:0];
                    inst_mem_data <= data_value[packetizer_pkg::inst_data_width-1:0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* source/packetizer_top.sv */
`timescale 1ns/10ps

module packetizer_top #(
    parameter int burst_count_width = 12,
    parameter int sync_stages = 2
) (
    input  logic                                        clk,
    input  logic                                        reset_n,
    input  logic                                        chip_select_n,
    input  logic [packetizer_pkg::word_width-1:0]       spi_word,
    input  logic                                        read_fifo_empty,
    output logic                                        rd_req,
    output logic [packetizer_pkg::act_addr_width-1:0]   act_mem_addr,
    output logic [packetizer_pkg::act_data_width-1:0]   act_mem_data,
    output logic                                        act_mem_wren,
    output logic [packetizer_pkg::param_addr_width-1:0] param_mem_addr,
    output logic [packetizer_pkg::param_data_width-1:0] param_mem_data,
    output logic                                        param_mem_wren,
    output logic [packetizer_pkg::inst_addr_width-1:0]  inst_mem_addr,
    output logic [packetizer_pkg::inst_data_width-1:0]  inst_mem_data,
    output logic                                        inst_mem_wren,
    output logic                                        proc_enable,
    output logic                                        proc_reset
);

    logic [packetizer_pkg::max_addr_width-1:0] addr_value;
    logic [packetizer_pkg::max_data_width-1:0] data_value;
    logic                                      commit;

    field_bus_if field_bus ();

    packet_sequencer #(
        .burst_count_width (burst_count_width),
        .sync_stages       (sync_stages)
    ) i_packet_sequencer (
        .clk             (clk),
        .reset_n         (reset_n),
        .chip_select_n   (chip_select_n),
        .spi_word        (spi_word),
        .read_fifo_empty (read_fifo_empty),
        .rd_req          (rd_req),
        .bus             (field_bus.sequencer),
        .commit          (commit),
        .proc_enable     (proc_enable),
        .proc_reset      (proc_reset)
    );

    address_builder i_address_builder (
        .clk        (clk),
        .reset_n    (reset_n),
        .bus        (field_bus.addr_side),
        .addr_value (addr_value)
    );

    data_builder i_data_builder (
        .clk        (clk),
        .reset_n    (reset_n),
        .bus        (field_bus.data_side),
        .data_value (data_value)
    );

    memory_router i_memory_router (
        .clk            (clk),
        .reset_n        (reset_n),
        .bus            (field_bus.router),
        .addr_value     (addr_value),
        .data_value     (data_value),
        .commit         (commit),
        .act_mem_addr   (act_mem_addr),
        .act_mem_data   (act_mem_data),
        .act_mem_wren   (act_mem_wren),
        .param_mem_addr (param_mem_addr),
        .param_mem_data (param_mem_data),
        .param_mem_wren (param_mem_wren),
        .inst_mem_addr  (inst_mem_addr),
        .inst_mem_data  (inst_mem_data),
        .inst_mem_wren  (inst_mem_wren)
    );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset drops before the first edge and holds for 16 cycles
    initial begin
        reset_n = 1'b1;
        #1 reset_n = 1'b0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

/* testbench/packetizer_checker.sv */
`timescale 1ns/10ps

module packetizer_checker (
    input logic         clk,
    input logic         reset_n,
    input logic [10:0]  act_mem_addr,
    input logic [7:0]   act_mem_data,
    input logic         act_mem_wren,
    input logic [12:0]  param_mem_addr,
    input logic [127:0] param_mem_data,
    input logic         param_mem_wren,
    input logic [5:0]   inst_mem_addr,
    input logic [79:0]  inst_mem_data,
    input logic         inst_mem_wren,
    input logic         proc_enable,
    input logic         proc_reset
);

    packetizer_pkg::target_e exp_target_q[$];
    logic [12:0]             exp_addr_q[$];
    logic [127:0]            exp_data_q[$];
    int                      error_count = 0;
    packetizer_pkg::target_e seen_target;
    packetizer_pkg::target_e exp_target;
    logic [12:0]             exp_addr;
    logic [127:0]            exp_data;

    task automatic push_write(packetizer_pkg::target_e target, logic [12:0] addr,
                              logic [127:0] data);
        exp_target_q.push_back(target);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    function automatic int pending();
        return exp_target_q.size();
    endfunction

    task automatic compare(string name, logic [127:0] expected, logic [127:0] actual);
        if (expected !== actual) begin
            $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, expected,
                     actual);
            error_count++;
        end
    endtask

    task automatic check_proc(logic exp_enable, logic exp_reset);
        compare("proc_enable", {127'b0, exp_enable}, {127'b0, proc_enable});
        compare("proc_reset", {127'b0, exp_reset}, {127'b0, proc_reset});
    endtask

    task automatic report_missing();
        while (exp_target_q.size() > 0) begin
            $display("Expected write to %s address %0h never happened",
                     exp_target_q[0].name(), exp_addr_q[0]);
            error_count++;
            void'(exp_target_q.pop_front());
            void'(exp_addr_q.pop_front());
            void'(exp_data_q.pop_front());
        end
    endtask

    // Outputs sampled at the edge that ends the wren cycle
    always @(posedge clk) begin
        if (reset_n && (act_mem_wren || param_mem_wren || inst_mem_wren)) begin
            if (act_mem_wren) seen_target = packetizer_pkg::target_act;
            else if (param_mem_wren) seen_target = packetizer_pkg::target_param;
            else seen_target = packetizer_pkg::target_inst;
            if (exp_target_q.size() == 0) begin
                $display("Unexpected write to %s memory at %0t ns", seen_target.name(), $time);
                error_count++;
            end else begin
                exp_target = exp_target_q.pop_front();
                exp_addr = exp_addr_q.pop_front();
                exp_data = exp_data_q.pop_front();
                compare("write target", {126'b0, exp_target}, {126'b0, seen_target});
                case (exp_target)
                    packetizer_pkg::target_act: begin
                        compare("act_mem_addr", exp_addr, act_mem_addr);
                        compare("act_mem_data", exp_data, act_mem_data);
                    end
                    packetizer_pkg::target_param: begin
                        compare("param_mem_addr", exp_addr, param_mem_addr);
                        compare("param_mem_data", exp_data, param_mem_data);
                    end
                    default: begin
                        compare("inst_mem_addr", exp_addr, inst_mem_addr);
                        compare("inst_mem_data", exp_data, inst_mem_data);
                    end
                endcase
            end
        end
    end

endmodule

/* testbench/packetizer_properties.sv */
`timescale 1ns/10ps

module packetizer_properties (
    input logic clk,
    input logic reset_n,
    input logic read_fifo_empty,
    input logic rd_req,
    input logic act_mem_wren,
    input logic param_mem_wren,
    input logic inst_mem_wren,
    input logic proc_enable,
    input logic proc_reset
);

    one_wren: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({act_mem_wren, param_mem_wren, inst_mem_wren}))
        else $error("more than one memory write enable high");

    // Idle cycle after every pop
    pop_spacing: assert property (@(posedge clk) disable iff (!reset_n)
        rd_req |=> !rd_req)
        else $error("rd_req high on two consecutive cycles");

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!reset_n)
        !(rd_req && read_fifo_empty))
        else $error("rd_req high while the FIFO is empty");

    quiet_in_reset: assert property (@(posedge clk)
        !reset_n |-> !(rd_req || act_mem_wren || param_mem_wren || inst_mem_wren
                       || proc_enable || proc_reset))
        else $error("outputs active during reset");

endmodule

bind packetizer_top packetizer_properties i_packetizer_properties (
    .clk             (clk),
    .reset_n         (reset_n),
    .read_fifo_empty (read_fifo_empty),
    .rd_req          (rd_req),
    .act_mem_wren    (act_mem_wren),
    .param_mem_wren  (param_mem_wren),
    .inst_mem_wren   (inst_mem_wren),
    .proc_enable     (proc_enable),
    .proc_reset      (proc_reset)
);

/* testbench/tb_packetizer.sv */
`timescale 1ns/10ps

module tb_packetizer;

    typedef struct {
        logic [7:0]  header;
        logic [15:0] burst_len;
        logic [15:0] addr;
        int          words;
        bit          abort;
    } row_t;

    localparam int num_rows = 13;

    // header, burst length, start address, words, abort
    row_t rows[num_rows] = '{
        '{8'h8C, 16'h0000, 16'h05A3, 1, 1'b0},
        '{8'hCC, 16'h0000, 16'h002B, 1, 1'b0},
        '{8'h4C, 16'h0000, 16'h1ABC, 1, 1'b0},
        '{8'h9D, 16'h0003, 16'h07FE, 4, 1'b0},
        '{8'h5E, 16'h0001, 16'h0010, 2, 1'b0},
        '{8'hDD, 16'h0002, 16'h003E, 3, 1'b0},
        '{8'h0E, 16'h0000, 16'h0000, 0, 1'b0},
        '{8'h0D, 16'h0000, 16'h0000, 0, 1'b0},
        '{8'h88, 16'h0000, 16'h0000, 1, 1'b0},
        '{8'hAC, 16'h0000, 16'h0000, 1, 1'b0},
        '{8'h4C, 16'h0000, 16'h0200, 1, 1'b1},
        '{8'h8C, 16'h0000, 16'h0123, 1, 1'b0},
        '{8'h0F, 16'h0000, 16'h0000, 0, 1'b0}
    };

    logic         clk;
    logic         reset_n;
    logic         chip_select_n;
    logic [7:0]   spi_word;
    logic         read_fifo_empty;
    logic         rd_req;
    logic [10:0]  act_mem_addr;
    logic [7:0]   act_mem_data;
    logic         act_mem_wren;
    logic [12:0]  param_mem_addr;
    logic [127:0] param_mem_data;
    logic         param_mem_wren;
    logic [5:0]   inst_mem_addr;
    logic [79:0]  inst_mem_data;
    logic         inst_mem_wren;
    logic         proc_enable;
    logic         proc_reset;

    integer     seed = 35777;
    logic [7:0] fifo_q[$];
    int         gap_q[$];
    int         gap_count = 0;
    int         errors;

    tb_clock_gen i_tb_clock_gen (.clk(clk), .reset_n(reset_n));

    packetizer_top #(.burst_count_width(12), .sync_stages(2)) i_packetizer_top (.*);

    packetizer_checker i_checker (.*);

    initial begin
        chip_select_n = 1'b1;
        spi_word = 8'h00;
        read_fifo_empty = 1'b1;
    end

    // Show-ahead FIFO model, a random gap after every pop
    always @(posedge clk) begin
        if (reset_n && rd_req) begin
            void'(fifo_q.pop_front());
            gap_count = gap_q.pop_front();
            read_fifo_empty <= 1'b1;
        end else if (gap_count > 0) begin
            gap_count = gap_count - 1;
        end else if (reset_n && fifo_q.size() > 0) begin
            spi_word <= fifo_q[0];
            read_fifo_empty <= 1'b0;
        end
    end

    function automatic bit is_mem_write(logic [7:0] header);
        return header[3:2] == 2'b11 && !header[5] && header[7:6] != 2'b00;
    endfunction

    function automatic int addr_width_of(packetizer_pkg::target_e target);
        case (target)
            packetizer_pkg::target_act:   return packetizer_pkg::act_addr_width;
            packetizer_pkg::target_param: return packetizer_pkg::param_addr_width;
            default:                      return packetizer_pkg::inst_addr_width;
        endcase
    endfunction

    function automatic int count_bytes();
        int total;
        packetizer_pkg::target_e target;
        total = 0;
        foreach (rows[r]) begin
            target = packetizer_pkg::target_e'(rows[r].header[7:6]);
            total += 1 + (rows[r].header[4] ? int'(rows[r].header[1:0]) : 0);
            total += packetizer_pkg::addr_bytes(target);
            total += rows[r].words * packetizer_pkg::data_bytes(target);
        end
        return total;
    endfunction

    task automatic push_byte(logic [7:0] value);
        fifo_q.push_back(value);
        gap_q.push_back($unsigned($random(seed)) % 4);
    endtask

    task automatic apply_row(row_t row);
        packetizer_pkg::target_e target;
        int          len_bytes;
        int          nbytes;
        logic [7:0]  b;
        logic [127:0] data;
        logic [15:0] addr;
        bit          mem_write;
        target = packetizer_pkg::target_e'(row.header[7:6]);
        len_bytes = row.header[4] ? int'(row.header[1:0]) : 0;
        mem_write = is_mem_write(row.header);
        @(posedge clk);
        chip_select_n <= 1'b0;
        @(negedge clk);
        push_byte(row.header);
        if (row.header[7:6] != 2'b00) begin
            for (int i = len_bytes - 1; i >= 0; i--) push_byte(row.burst_len[8*i +: 8]);
            for (int i = packetizer_pkg::addr_bytes(target) - 1; i >= 0; i--) begin
                push_byte(row.addr[8*i +: 8]);
            end
            for (int w = 0; w < row.words; w++) begin
                data = '0;
                nbytes = packetizer_pkg::data_bytes(target);
                // Abort rows stop one byte short of the first word
                if (row.abort) nbytes = nbytes - 1;
                for (int j = 0; j < nbytes; j++) begin
                    b = $random(seed);
                    // Bytes after a rejected header must also decode as invalid headers
                    if (!mem_write) b = b & 8'hF3;
                    push_byte(b);
                    data = {data[119:0], b};
                end
                addr = (row.addr + w) & ((16'd1 << addr_width_of(target)) - 1);
                if (mem_write && !row.abort) i_checker.push_write(target, addr[12:0], data);
                if (row.abort) break;
            end
        end
        while (fifo_q.size() > 0 || i_checker.pending() > 0) @(posedge clk);
        repeat (20) @(posedge clk);
        if (row.header[7:2] == 6'b000011) i_checker.check_proc(row.header[1], row.header[0]);
        chip_select_n <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    initial begin
        wait (reset_n === 1'b1);
        repeat (4) @(posedge clk);
        foreach (rows[r]) apply_row(rows[r]);
        i_checker.report_missing();
        errors = i_checker.error_count;
        $display("Run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the bytes in the table
    initial begin
        longint limit;
        limit = (40 + count_bytes() * 10 + num_rows * 80) * 4;
        #(limit);
        $display("Timeout after %0d ns with %0d writes still expected", limit,
                 i_checker.pending());
        $display("Finished with errors");
        $finish;
    end

endmodule

/* list.f */
source/packetizer_pkg.sv
source/field_bus_if.sv
source/packet_sequencer.sv
source/address_builder.sv
source/data_builder.sv
source/memory_router.sv
source/packetizer_top.sv
testbench/tb_clock_gen.sv
testbench/packetizer_checker.sv
testbench/packetizer_properties.sv
testbench/tb_packetizer.sv

/* Makefile */
TOP = tb_packetizer

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir
